// File: design/npc_pkg.sv
package npc_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // one bit per supported operation
    typedef logic [8:0]  alu_op_t;

    // bit positions inside alu_op_t
    localparam int OP_AUIPC = 0;
    localparam int OP_LUI   = 1;
    localparam int OP_JAL   = 2;
    localparam int OP_JALR  = 3;
    localparam int OP_ADDI  = 4;
    localparam int OP_ADD   = 5;
    localparam int OP_LW    = 6;
    localparam int OP_LBU   = 7;
    localparam int OP_SW    = 8;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // full ebreak encoding
    localparam word_t INST_EBREAK = 32'h00100073;

endpackage

// File: design/inst_decoder.sv
module inst_decoder (
    input  npc_pkg::word_t     inst,
    output npc_pkg::reg_addr_t rs1,
    output npc_pkg::reg_addr_t rs2,
    output npc_pkg::reg_addr_t rd,
    output npc_pkg::word_t     imm,
    output npc_pkg::alu_op_t   alu_op,
    output logic               reg_wen,
    output logic               mem_wen,
    output logic               byte_load,
    output logic               halt_req
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    npc_pkg::word_t imm_i;
    npc_pkg::word_t imm_s;
    npc_pkg::word_t imm_u;
    npc_pkg::word_t imm_j;

    logic is_i_type;
    logic is_s_type;
    logic is_u_type;
    logic is_j_type;

    // instruction fields
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // immediates, all sign extended from inst[31]
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // one-hot operation, direct compares on opcode and funct3
    always_comb begin
        alu_op = '0;
        alu_op[npc_pkg::OP_LUI]   = (opcode == npc_pkg::OPC_LUI);
        alu_op[npc_pkg::OP_AUIPC] = (opcode == npc_pkg::OPC_AUIPC);
        alu_op[npc_pkg::OP_JAL]   = (opcode == npc_pkg::OPC_JAL);
        alu_op[npc_pkg::OP_JALR]  = (opcode == npc_pkg::OPC_JALR) && (funct3 == 3'b000);
        alu_op[npc_pkg::OP_ADDI]  = (opcode == npc_pkg::OPC_OPIMM) && (funct3 == 3'b000);
        alu_op[npc_pkg::OP_ADD]   = (opcode == npc_pkg::OPC_OP) && (funct3 == 3'b000)
                                    && (funct7 == 7'b0000000);
        alu_op[npc_pkg::OP_LW]    = (opcode == npc_pkg::OPC_LOAD) && (funct3 == 3'b010);
        alu_op[npc_pkg::OP_LBU]   = (opcode == npc_pkg::OPC_LOAD) && (funct3 == 3'b100);
        alu_op[npc_pkg::OP_SW]    = (opcode == npc_pkg::OPC_STORE) && (funct3 == 3'b010);
    end

    // immediate format per operation
    assign is_i_type = alu_op[npc_pkg::OP_JALR] | alu_op[npc_pkg::OP_ADDI]
                     | alu_op[npc_pkg::OP_LW] | alu_op[npc_pkg::OP_LBU];
    assign is_s_type = alu_op[npc_pkg::OP_SW];
    assign is_u_type = alu_op[npc_pkg::OP_LUI] | alu_op[npc_pkg::OP_AUIPC];
    assign is_j_type = alu_op[npc_pkg::OP_JAL];

    assign imm = ({32{is_i_type}} & imm_i)
               | ({32{is_s_type}} & imm_s)
               | ({32{is_u_type}} & imm_u)
               | ({32{is_j_type}} & imm_j);

    // every op except sw writes rd, unknown encodings write nothing
    assign reg_wen   = |alu_op & ~alu_op[npc_pkg::OP_SW];
    assign mem_wen   = alu_op[npc_pkg::OP_SW];
    assign byte_load = alu_op[npc_pkg::OP_LBU];

    // only the exact ebreak word halts
    assign halt_req  = (inst == npc_pkg::INST_EBREAK);

endmodule

// File: design/alu.sv
module alu (
    input  npc_pkg::word_t   pc,
    input  npc_pkg::word_t   src1,
    input  npc_pkg::word_t   src2,
    input  npc_pkg::word_t   imm,
    input  npc_pkg::word_t   rdata,
    input  npc_pkg::alu_op_t alu_op,
    output npc_pkg::word_t   mem_addr,
    output npc_pkg::word_t   result
);

    npc_pkg::word_t pc_plus_imm;
    npc_pkg::word_t pc_plus_4;
    npc_pkg::word_t src_sum;
    logic           is_link;
    logic           is_load;

    // shared adders
    assign pc_plus_imm = pc + imm;
    assign pc_plus_4   = pc + 32'd4;
    assign src_sum     = src1 + src2;

    // load/store address, also the jalr target before bit 0 is cleared
    assign mem_addr = src1 + imm;

    assign is_link = alu_op[npc_pkg::OP_JAL] | alu_op[npc_pkg::OP_JALR];
    assign is_load = alu_op[npc_pkg::OP_LW] | alu_op[npc_pkg::OP_LBU];

    // and-or mux over the one-hot select; sw and nop fall through to zero
    assign result = ({32{alu_op[npc_pkg::OP_AUIPC]}} & pc_plus_imm)
                  | ({32{alu_op[npc_pkg::OP_LUI]}}   & imm)
                  | ({32{is_link}}                   & pc_plus_4)
                  | ({32{alu_op[npc_pkg::OP_ADDI]}}  & mem_addr)
                  | ({32{alu_op[npc_pkg::OP_ADD]}}   & src_sum)
                  | ({32{is_load}}                   & rdata);

endmodule

// File: design/register_file.sv
module register_file (
    input  logic               clk,
    input  logic               wen,
    input  npc_pkg::reg_addr_t waddr,
    input  npc_pkg::reg_addr_t raddr1,
    input  npc_pkg::reg_addr_t raddr2,
    input  npc_pkg::word_t     wdata,
    output npc_pkg::word_t     rdata1,
    output npc_pkg::word_t     rdata2
);

    npc_pkg::word_t regs [32];

    // single write port, x0 never written
    always_ff @(posedge clk) begin
        if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: design/data_memory.sv
module data_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           wen,
    input  npc_pkg::word_t addr,
    input  npc_pkg::word_t wdata,
    input  logic           byte_load,
    output npc_pkg::word_t rdata
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    npc_pkg::word_t mem [DMEM_WORDS];

    logic [IDX_W-1:0] index;
    npc_pkg::word_t   word;
    logic [7:0]       byte_sel;

    // word index wraps at the memory depth
    assign index = addr[IDX_W+1:2];
    assign word  = mem[index];

    // little-endian byte lane
    always_comb begin
        case (addr[1:0])
            2'd0:    byte_sel = word[7:0];
            2'd1:    byte_sel = word[15:8];
            2'd2:    byte_sel = word[23:16];
            default: byte_sel = word[31:24];
        endcase
    end

    assign rdata = byte_load ? {24'b0, byte_sel} : word;

    // whole-word store
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[index] <= wdata;
        end
    end

endmodule

// File: design/npc.sv
module npc #(
    parameter npc_pkg::word_t RESET_PC   = 32'h80000000,
    parameter int             DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  npc_pkg::word_t     inst,
    output npc_pkg::word_t     pc,
    output npc_pkg::word_t     alu_result,
    output logic               reg_wen,
    output npc_pkg::reg_addr_t rd,
    output logic               halted
);

    npc_pkg::reg_addr_t rs1;
    npc_pkg::reg_addr_t rs2;
    npc_pkg::word_t     imm;
    npc_pkg::alu_op_t   alu_op;
    npc_pkg::word_t     src1;
    npc_pkg::word_t     src2;
    npc_pkg::word_t     mem_addr;
    npc_pkg::word_t     mem_rdata;
    npc_pkg::word_t     next_pc;
    logic               dec_reg_wen;
    logic               dec_mem_wen;
    logic               byte_load;
    logic               halt_req;

    inst_decoder u_decoder (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .reg_wen   (dec_reg_wen),
        .mem_wen   (dec_mem_wen),
        .byte_load (byte_load),
        .halt_req  (halt_req)
    );

    // write strobe seen outside, suppressed once halted
    assign reg_wen = dec_reg_wen & ~halted;

    register_file u_regfile (
        .clk    (clk),
        .wen    (reg_wen & ~reset),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (alu_result),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    alu u_alu (
        .pc       (pc),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .rdata    (mem_rdata),
        .alu_op   (alu_op),
        .mem_addr (mem_addr),
        .result   (alu_result)
    );

    data_memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk       (clk),
        .wen       (dec_mem_wen & ~halted & ~reset),
        .addr      (mem_addr),
        .wdata     (src2),
        .byte_load (byte_load),
        .rdata     (mem_rdata)
    );

    // jal relative to pc, jalr from src1 + imm with bit 0 cleared
    assign next_pc = alu_op[npc_pkg::OP_JAL]  ? pc + imm :
                     alu_op[npc_pkg::OP_JALR] ? {mem_addr[31:1], 1'b0} :
                     pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            pc     <= next_pc;
            // sticky until the next reset
            halted <= halt_req;
        end
    end

endmodule

// File: verification/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // power-on reset for 10 cycles, dropped on a falling edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

// File: verification/npc_chk.sv
module npc_chk (
    input logic           clk,
    input logic           reset,
    input npc_pkg::word_t inst,
    input npc_pkg::word_t pc,
    input logic           halted
);

    timeunit 1ns;
    timeprecision 1ps;

    // count of failed assertions
    int fail_count = 0;

    // fetch addresses stay word aligned
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc %h is not word aligned", pc);
            fail_count++;
        end

    // pc frozen once halted
    pc_held: assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
        else begin
            $error("pc moved while halted");
            fail_count++;
        end

    // halted only rises after an ebreak
    halt_on_ebreak: assert property (@(posedge clk) disable iff (reset)
        (!halted && (inst != npc_pkg::INST_EBREAK)) |=> !halted)
        else begin
            $error("halted set without an ebreak");
            fail_count++;
        end

    // reset always clears halt
    halt_cleared: assert property (@(posedge clk) reset |=> !halted)
        else begin
            $error("halted still set after reset");
            fail_count++;
        end

endmodule

bind npc npc_chk u_chk (
    .clk    (clk),
    .reset  (reset),
    .inst   (inst),
    .pc     (pc),
    .halted (halted)
);

// File: verification/npc_tb.sv
module npc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam npc_pkg::word_t RESET_PC = 32'h80000000;

    logic clk, por, tb_reset, reset, reg_wen, halted;
    npc_pkg::word_t     inst, pc, alu_result;
    npc_pkg::reg_addr_t rd;

    // program table, one entry per instruction
    int                 q_grp [$];
    npc_pkg::word_t     q_inst [$], q_res [$], q_next [$];
    logic               q_wen [$];
    npc_pkg::reg_addr_t q_rd [$];
    bit                 q_rst [$];

    // table builder state
    npc_pkg::word_t mpc;
    int cur_grp = 0;
    bit model_halted = 1'b0;
    bit rst_pending = 1'b0;

    int errors = 0, checks = 0, grp_err = 0, tests_run = 0, tests_failed = 0, cur_row = -1;
    bit timed_out = 1'b0;
    integer seed;

    assign reset = por | tb_reset;

    clock_gen u_clk (.clk(clk), .reset(por));

    npc #(.RESET_PC(RESET_PC), .DMEM_WORDS(256)) uut (
        .clk(clk), .reset(reset), .inst(inst), .pc(pc), .alu_result(alu_result),
        .reg_wen(reg_wen), .rd(rd), .halted(halted)
    );

    // instruction encoders
    function automatic npc_pkg::word_t enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd_f,
                                             logic [4:0] rs1, logic [11:0] imm);
        enc_i = {imm, rs1, f3, rd_f, opc};
    endfunction

    function automatic npc_pkg::word_t enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], npc_pkg::OPC_STORE};
    endfunction

    function automatic npc_pkg::word_t enc_u(logic [6:0] opc, logic [4:0] rd_f, logic [19:0] imm);
        enc_u = {imm, rd_f, opc};
    endfunction

    function automatic npc_pkg::word_t enc_j(logic [4:0] rd_f, logic [20:0] off);
        enc_j = {off[20], off[10:1], off[11], off[19:12], rd_f, npc_pkg::OPC_JAL};
    endfunction

    function automatic npc_pkg::word_t enc_r(logic [4:0] rd_f, logic [4:0] rs1, logic [4:0] rs2);
        enc_r = {7'b0, rs2, rs1, 3'b000, rd_f, npc_pkg::OPC_OP};
    endfunction

    task push_row(npc_pkg::word_t i_w, npc_pkg::word_t res, logic wen, npc_pkg::reg_addr_t r,
                  npc_pkg::word_t nxt);
        q_grp.push_back(cur_grp);
        q_inst.push_back(i_w);
        q_res.push_back(res);
        q_wen.push_back(wen);
        q_rd.push_back(r);
        q_next.push_back(nxt);
        q_rst.push_back(rst_pending);
        rst_pending = 1'b0;
        mpc = nxt;
    endtask

    // a halted core keeps pc and drops the write strobe
    task add_row(npc_pkg::word_t i_w, npc_pkg::word_t res, logic wen, npc_pkg::reg_addr_t r);
        push_row(i_w, res, wen & ~model_halted, r, model_halted ? mpc : mpc + 32'd4);
    endtask

    task add_jump(npc_pkg::word_t i_w, npc_pkg::word_t res, npc_pkg::reg_addr_t r,
                  npc_pkg::word_t target);
        push_row(i_w, res, ~model_halted, r, model_halted ? mpc : target);
    endtask

    task build_table;
        npc_pkg::word_t rnd, va, vb, x5_val, x14_val, stored, shifted, a;
        logic [11:0] ra, rb, off;
        rnd = $random(seed);
        ra = rnd[11:0];
        rnd = $random(seed);
        rb = rnd[11:0];
        va = {{20{ra[11]}}, ra};
        vb = {{20{rb[11]}}, rb};
        x5_val = 32'h12345678 + va + vb;
        stored = 32'hf0e1d3c2;
        // the all-zero word during the first live cycle is a nop
        mpc = RESET_PC + 32'd4;
        cur_grp = 2;
        add_row(enc_u(npc_pkg::OPC_LUI, 5'd1, 20'h12345), 32'h12345000, 1'b1, 5'd1);
        add_row(enc_i(npc_pkg::OPC_OPIMM, 3'd0, 5'd1, 5'd1, 12'h678), 32'h12345678, 1'b1, 5'd1);
        add_row(enc_i(npc_pkg::OPC_OPIMM, 3'd0, 5'd2, 5'd0, ra), va, 1'b1, 5'd2);
        add_row(enc_i(npc_pkg::OPC_OPIMM, 3'd0, 5'd3, 5'd0, rb), vb, 1'b1, 5'd3);
        add_row(enc_r(5'd4, 5'd2, 5'd3), va + vb, 1'b1, 5'd4);
        add_row(enc_r(5'd5, 5'd1, 5'd4), x5_val, 1'b1, 5'd5);
        add_row(enc_u(npc_pkg::OPC_AUIPC, 5'd6, 20'h00001), mpc + 32'h1000, 1'b1, 5'd6);
        // x0 takes the write but still reads zero
        add_row(enc_i(npc_pkg::OPC_OPIMM, 3'd0, 5'd0, 5'd1, 12'd5), 32'h1234567d, 1'b1, 5'd0);
        add_row(enc_r(5'd7, 5'd0, 5'd1), 32'h12345678, 1'b1, 5'd7);
        cur_grp = 3;
        add_row(enc_u(npc_pkg::OPC_LUI, 5'd13, 20'hf0e1d), 32'hf0e1d000, 1'b1, 5'd13);
        add_row(enc_i(npc_pkg::OPC_OPIMM, 3'd0, 5'd13, 5'd13, 12'h3c2), stored, 1'b1, 5'd13);
        add_row(enc_s(5'd0, 5'd13, 12'h040), 32'd0, 1'b0, 5'd0);
        add_row(enc_i(npc_pkg::OPC_LOAD, 3'b010, 5'd8, 5'd0, 12'h040), stored, 1'b1, 5'd8);
        // little-endian byte lanes, zero extended
        for (off = 12'h040; off < 12'h044; off = off + 12'd1) begin
            shifted = stored >> {off[1:0], 3'b000};
            add_row(enc_i(npc_pkg::OPC_LOAD, 3'b100, 5'd9, 5'd0, off), {24'b0, shifted[7:0]},
                    1'b1, 5'd9);
        end
        cur_grp = 4;
        x14_val = mpc + 32'd4;
        add_jump(enc_j(5'd14, 21'd16), x14_val, 5'd14, mpc + 32'd16);
        a = mpc;
        add_row(enc_u(npc_pkg::OPC_AUIPC, 5'd15, 20'h0), a, 1'b1, 5'd15);
        add_jump(enc_i(npc_pkg::OPC_JALR, 3'd0, 5'd16, 5'd15, 12'h021), mpc + 32'd4, 5'd16,
                 (a + 32'h21) & ~32'd1);
        add_jump(enc_j(5'd0, 21'h1ffff8), mpc + 32'd4, 5'd0, mpc - 32'd8);
        cur_grp = 5;
        add_row(npc_pkg::INST_EBREAK, 32'd0, 1'b0, 5'd0);
        model_halted = 1'b1;
        add_row(enc_i(npc_pkg::OPC_OPIMM, 3'd0, 5'd5, 5'd0, 12'd99), 32'd99, 1'b1, 5'd5);
        add_row(enc_s(5'd0, 5'd1, 12'h040), 32'd0, 1'b0, 5'd0);
        add_jump(enc_j(5'd14, 21'd16), mpc + 32'd4, 5'd14, mpc + 32'd16);
        // read back after a fresh reset
        model_halted = 1'b0;
        mpc = RESET_PC + 32'd4;
        rst_pending = 1'b1;
        add_row(enc_r(5'd17, 5'd5, 5'd0), x5_val, 1'b1, 5'd17);
        add_row(enc_i(npc_pkg::OPC_LOAD, 3'b010, 5'd18, 5'd0, 12'h040), stored, 1'b1, 5'd18);
        add_row(enc_r(5'd19, 5'd14, 5'd0), x14_val, 1'b1, 5'd19);
    endtask

    task check(string sig, npc_pkg::word_t got, npc_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s = %h, expected %h (row %0d)", sig, got, exp, cur_row);
            errors++;
            grp_err++;
        end
    endtask

    task wait_reset_release;
        int n;
        n = 0;
        #1;
        while (reset !== 1'b0 && n < 40) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task wait_halted;
        int n;
        n = 0;
        while (halted !== 1'b1 && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: halted did not rise after ebreak");
            timed_out = 1'b1;
        end
    endtask

    // inst is all zero here
    task check_reset_state;
        check("pc", pc, RESET_PC);
        check("halted", {31'b0, halted}, 32'd0);
        check("reg_wen", {31'b0, reg_wen}, 32'd0);
    endtask

    task apply_reset;
        @(negedge clk);
        inst = '0;
        tb_reset = 1'b1;
        repeat (4) @(negedge clk);
        tb_reset = 1'b0;
        wait_reset_release();
        if (!timed_out) begin
            check_reset_state();
        end
    endtask

    function automatic string test_name(int g);
        case (g)
            1:       test_name = "reset state";
            2:       test_name = "lui addi add auipc";
            3:       test_name = "sw lw lbu";
            4:       test_name = "jal jalr";
            default: test_name = "ebreak halt";
        endcase
    endfunction

    task report_test(int g);
        tests_run++;
        if (grp_err != 0) begin
            tests_failed++;
        end
        $display("test %0d %-20s %s", g, test_name(g), (grp_err == 0) ? "pass" : "fail");
        grp_err = 0;
    endtask

    task run_table;
        int i, n;
        n = q_inst.size();
        for (i = 0; i < n; i++) begin
            cur_row = i;
            if (q_rst[i]) begin
                apply_reset();
                if (timed_out) begin
                    break;
                end
            end
            @(negedge clk);
            inst = q_inst[i];
            #2;
            check("alu_result", alu_result, q_res[i]);
            check("reg_wen", {31'b0, reg_wen}, {31'b0, q_wen[i]});
            check("rd", {27'b0, rd}, {27'b0, q_rd[i]});
            @(posedge clk);
            #1;
            check("pc", pc, q_next[i]);
            if (q_inst[i] == npc_pkg::INST_EBREAK) begin
                wait_halted();
                if (timed_out) begin
                    break;
                end
            end
            if (i == n - 1 || q_grp[i + 1] != q_grp[i]) begin
                report_test(q_grp[i]);
            end
        end
    endtask

    initial begin
        inst = '0;
        tb_reset = 1'b0;
        seed = 32'h480d;
        build_table();
        wait_reset_release();
        if (!timed_out) begin
            check_reset_state();
            report_test(1);
            run_table();
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion fails",
                 tests_run, tests_failed, checks, errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog.f
design/npc_pkg.sv
design/inst_decoder.sv
design/alu.sv
design/register_file.sv
design/data_memory.sv
design/npc.sv
verification/clock_gen.sv
verification/npc_chk.sv
verification/npc_tb.sv

// File: Makefile
SRCS := $(wildcard design/*.sv verification/*.sv)

all: run

obj_dir/npc_sim: verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module npc_tb -f verilog.f -o npc_sim

run: obj_dir/npc_sim
	./obj_dir/npc_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
